// File: Makefile
TOOL     = verilator
TOP      = mos_control_tb
FILELIST = project.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail if the log reports a failure"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/mos_control_properties.sv
`timescale 1ns/1ns

module mos_control_properties (
	input logic       clk,
	input logic       rst_n,
	input logic [1:0] mosfet_buck1,
	input logic [1:0] mosfet_buck2,
	input logic [1:0] mosfet_res1,
	input logic [1:0] mosfet_res2
);
	import discharge_mode_pkg::*;

	int fail_count = 0; // failed assertions so far

	// both switches of one leg on shorts the supply
	no_short_buck1: assert property (@(posedge clk) disable iff (!rst_n) mosfet_buck1 != 2'b11)
		else
		begin
			fail_count++;
			$error("buck1 leg has both switches on");
		end
	no_short_buck2: assert property (@(posedge clk) disable iff (!rst_n) mosfet_buck2 != 2'b11)
		else
		begin
			fail_count++;
			$error("buck2 leg has both switches on");
		end
	no_short_res1: assert property (@(posedge clk) disable iff (!rst_n) mosfet_res1 != 2'b11)
		else
		begin
			fail_count++;
			$error("res1 leg has both switches on");
		end
	no_short_res2: assert property (@(posedge clk) disable iff (!rst_n) mosfet_res2 != 2'b11)
		else
		begin
			fail_count++;
			$error("res2 leg has both switches on");
		end

	// buck legs pass through off, never a direct swap
	buck1_up_down: assert property (@(posedge clk) disable iff (!rst_n)
		(mosfet_buck1 == leg_up) |=> (mosfet_buck1 != leg_down))
		else
		begin
			fail_count++;
			$error("buck1 went from up to down without dead time");
		end
	buck1_down_up: assert property (@(posedge clk) disable iff (!rst_n)
		(mosfet_buck1 == leg_down) |=> (mosfet_buck1 != leg_up))
		else
		begin
			fail_count++;
			$error("buck1 went from down to up without dead time");
		end
	buck2_up_down: assert property (@(posedge clk) disable iff (!rst_n)
		(mosfet_buck2 == leg_up) |=> (mosfet_buck2 != leg_down))
		else
		begin
			fail_count++;
			$error("buck2 went from up to down without dead time");
		end
	buck2_down_up: assert property (@(posedge clk) disable iff (!rst_n)
		(mosfet_buck2 == leg_down) |=> (mosfet_buck2 != leg_up))
		else
		begin
			fail_count++;
			$error("buck2 went from down to up without dead time");
		end

endmodule

// File: dv/mos_control_tb.sv
`timescale 1ns/1ns

module mos_control_tb;
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	localparam int clk_period = 40;
	localparam int ton_us = 1;
	localparam int toff_us = 2;
	localparam int buck_ton_us = 20;     // five buck periods fit
	localparam int ton_len = ton_us * us_cycles;
	localparam int toff_len = toff_us * us_cycles;
	// one deion per test, the wait timeout, two res pulses, the buck pulse, margin
	localparam int watchdog_cycles = 4 * (toff_len + 50) + wait_breakdown_max_cycles
		+ 2 * ton_len + buck_ton_us * us_cycles + 2000;

	localparam int sel_buck1 = 0;        // output selectors
	localparam int sel_buck2 = 1;
	localparam int sel_res1 = 2;
	localparam int sel_res2 = 3;
	localparam int sel_deion = 4;
	localparam int sel_breakdown = 5;
	localparam int sel_operation = 6;

	localparam int mode_noise = 0;       // gap open, nothing qualifies
	localparam int mode_fire = 1;        // low voltage, current flowing
	localparam int mode_overcurrent = 2;

	logic                       clk;
	logic                       rst_n;
	logic                       is_machine;
	logic [15:0]                waveform;
	logic [15:0]                ton;
	logic [15:0]                toff;
	logic signed [sample_w-1:0] sample_current;
	logic signed [sample_w-1:0] sample_voltage;
	logic [1:0]                 mosfet_buck1;
	logic [1:0]                 mosfet_buck2;
	logic [1:0]                 mosfet_res1;
	logic [1:0]                 mosfet_res2;
	logic                       mosfet_deion;
	logic                       is_operation;
	logic                       is_breakdown;

	integer     seed;
	int         gap_mode;
	int         n_checks;
	int         n_errors;
	int         n_timeouts;
	int         cycle = 0;
	int         buck1_starts[$];     // cycle of each up edge
	int         buck2_starts[$];
	logic [1:0] buck1_prev = 2'b00;
	logic [1:0] buck2_prev = 2'b00;

	mos_control UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.is_machine     (is_machine),
		.waveform       (waveform),
		.ton            (ton),
		.toff           (toff),
		.sample_current (sample_current),
		.sample_voltage (sample_voltage),
		.mosfet_buck1   (mosfet_buck1),
		.mosfet_buck2   (mosfet_buck2),
		.mosfet_res1    (mosfet_res1),
		.mosfet_res2    (mosfet_res2),
		.mosfet_deion   (mosfet_deion),
		.is_operation   (is_operation),
		.is_breakdown   (is_breakdown)
	);

	bind gate_driver mos_control_properties leg_checks (
		.clk          (clk),
		.rst_n        (rst_n),
		.mosfet_buck1 (mosfet_buck1),
		.mosfet_buck2 (mosfet_buck2),
		.mosfet_res1  (mosfet_res1),
		.mosfet_res2  (mosfet_res2)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// adc model, random values inside the chosen range
	always @(posedge clk)
	begin
		case (gap_mode)
			mode_fire:
			begin
				sample_voltage <= sample_w'($random(seed) & 31);
				sample_current <= sample_w'(11 + ($random(seed) & 15)); // doubled stays under limit
			end
			mode_overcurrent:
			begin
				sample_voltage <= sample_w'(200 + ($random(seed) & 63));
				sample_current <= sample_w'(39 + ($random(seed) & 15)); // doubled is above 76
			end
			default:
			begin
				sample_voltage <= sample_w'(200 + ($random(seed) & 63));
				sample_current <= sample_w'($random(seed) & 7);
			end
		endcase
	end

	// up edges of the buck legs for the phase check
	always @(negedge clk)
	begin
		cycle = cycle + 1;
		if (mosfet_buck1 == leg_up && buck1_prev != leg_up)
			buck1_starts.push_back(cycle);
		if (mosfet_buck2 == leg_up && buck2_prev != leg_up)
			buck2_starts.push_back(cycle);
		buck1_prev = mosfet_buck1;
		buck2_prev = mosfet_buck2;
	end

	function automatic logic [1:0] out_value(input int sel);
		logic [1:0] v;
		case (sel)
			sel_buck1: v = mosfet_buck1;
			sel_buck2: v = mosfet_buck2;
			sel_res1: v = mosfet_res1;
			sel_res2: v = mosfet_res2;
			sel_deion: v = {1'b0, mosfet_deion};
			sel_breakdown: v = {1'b0, is_breakdown};
			default: v = {1'b0, is_operation};
		endcase
		return v;
	endfunction

	function automatic string out_name(input int sel);
		string s;
		case (sel)
			sel_buck1: s = "mosfet_buck1";
			sel_buck2: s = "mosfet_buck2";
			sel_res1: s = "mosfet_res1";
			sel_res2: s = "mosfet_res2";
			sel_deion: s = "mosfet_deion";
			sel_breakdown: s = "is_breakdown";
			default: s = "is_operation";
		endcase
		return s;
	endfunction

	task automatic check_eq(input int sel, input logic [1:0] exp);
		n_checks++;
		if (out_value(sel) !== exp)
		begin
			n_errors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, out_name(sel),
				out_value(sel), exp);
		end
	endtask

	task automatic check_len(input string name, input int got, input int lo, input int hi);
		n_checks++;
		if (got < lo || got > hi)
		begin
			n_errors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d to %0d", $time, name, got, lo, hi);
		end
	endtask

	// polls on negedges, call only at a negedge
	task automatic wait_out(input int sel, input logic [1:0] val, input int limit);
		int n;
		n = 0;
		while (out_value(sel) !== val && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (out_value(sel) !== val)
		begin
			n_timeouts++;
			$display("%s did not reach %b within %0d cycles, at %0t ns", out_name(sel), val,
				limit, $time);
		end
	endtask

	task automatic run_length(input int sel, input logic [1:0] val, input int limit,
		output int len);
		len = 0;
		while (out_value(sel) === val && len < limit)
		begin
			len++;
			@(negedge clk);
		end
	endtask

	task automatic test_reset();
		int s;
		repeat (2) @(posedge clk);
		@(negedge clk);
		for (s = sel_buck1; s <= sel_operation; s++)
			check_eq(s, 2'b00); // everything quiet in reset
		@(posedge clk);
		rst_n      <= 1'b1;     // third edge in reset
		is_machine <= 1'b1;
		@(negedge clk);
		wait_out(sel_deion, 2'b01, dead_time_cycles + 5);
		for (s = sel_buck1; s <= sel_res2; s++)
			check_eq(s, leg_down);
		wait_out(sel_deion, 2'b00, toff_len);
		for (s = sel_buck1; s <= sel_res2; s++)
			check_eq(s, leg_off); // opened before wait
		check_eq(sel_operation, 2'b01);
	endtask

	task automatic test_wait_timeout();
		int len;
		wait_out(sel_res1, leg_up, 2 * dead_time_cycles + 5);
		check_eq(sel_buck1, leg_off);
		check_eq(sel_buck2, leg_off);
		check_eq(sel_res2, leg_off);
		run_length(sel_res1, leg_up, wait_breakdown_max_cycles + 20, len);
		check_len("res1 up time without breakdown", len, wait_breakdown_max_cycles,
			wait_breakdown_max_cycles + 5);
		check_eq(sel_res1, leg_down); // back to deion entry
		check_eq(sel_deion, 2'b00);
	endtask

	task automatic test_res_discharge();
		int len;
		wait_out(sel_res1, leg_up, toff_len + 20);
		gap_mode = mode_fire;
		run_length(sel_breakdown, 2'b00, breakdown_qual_cycles + 5, len);
		gap_mode = mode_noise;
		// one edge for the sample to land, then the qualifying samples
		check_len("cycles to breakdown", len, breakdown_qual_cycles + 1,
			breakdown_qual_cycles + 1);
		check_eq(sel_breakdown, 2'b01);
		check_eq(sel_res1, leg_up);
		run_length(sel_res1, leg_up, ton_len + 20, len);
		check_len("res1 discharge time", len, ton_len, ton_len + 5);
		check_eq(sel_res1, leg_down);
		check_eq(sel_breakdown, 2'b00);
		check_eq(sel_buck1, leg_off);
	endtask

	task automatic test_buck();
		int p;
		int i;
		int len;
		int exp_charge;
		@(posedge clk);
		waveform <= wave_buck_openloop;
		ton      <= 16'(buck_ton_us);
		@(negedge clk);
		wait_out(sel_res1, leg_up, toff_len + 20);
		buck1_starts.delete();
		buck2_starts.delete();
		gap_mode = mode_fire;
		wait_out(sel_breakdown, 2'b01, breakdown_qual_cycles + 5);
		gap_mode = mode_noise;
		for (p = 0; p <= rise_period_count; p++)
		begin
			exp_charge = (p < rise_period_count) ? rise_charge_cycles : stand_charge_cycles;
			wait_out(sel_buck1, leg_up, buck_period_cycles);
			run_length(sel_buck1, leg_up, buck_period_cycles, len);
			check_len("buck1 up time", len, exp_charge, exp_charge);
			run_length(sel_buck1, leg_off, buck_period_cycles, len);
			check_len("buck1 off after up", len, dead_time_cycles, dead_time_cycles);
			check_eq(sel_buck1, leg_down);
			run_length(sel_buck1, leg_down, buck_period_cycles, len); // freewheel
			run_length(sel_buck1, leg_off, buck_period_cycles, len);
			check_len("buck1 off before up", len, dead_time_cycles, dead_time_cycles);
		end
		if (buck2_starts.size() < rise_period_count || buck1_starts.size() < rise_period_count)
		begin
			n_errors++;
			$display("too few buck up pulses seen, buck1 %0d, buck2 %0d, at %0t ns",
				buck1_starts.size(), buck2_starts.size(), $time);
		end
		else
		begin
			for (i = 0; i < rise_period_count; i++)
				check_len("buck2 delay after buck1", buck2_starts[i] - buck1_starts[i],
					buck_half_cycles, buck_half_cycles);
		end
		wait_out(sel_deion, 2'b01, buck_ton_us * us_cycles);
		check_eq(sel_buck1, leg_down);
		check_eq(sel_buck2, leg_down);
		@(posedge clk);
		waveform <= wave_res_discharge;
		ton      <= 16'(ton_us);
		@(negedge clk);
	endtask

	task automatic test_overcurrent();
		int s;
		wait_out(sel_res1, leg_up, toff_len + 20);
		check_eq(sel_operation, 2'b01);
		gap_mode = mode_overcurrent;
		// sample lands on the next edge, then two registers
		wait_out(sel_operation, 2'b00, 3);
		gap_mode = mode_noise;
		wait_out(sel_res1, leg_down, 5);
		wait_out(sel_deion, 2'b01, dead_time_cycles + 5);
		for (s = sel_buck1; s <= sel_res2; s++)
			check_eq(s, leg_down);
		wait_out(sel_operation, 2'b01, 5); // recovers once the sample is back
	endtask

	initial
	begin
		seed           = 32'hc99f;
		rst_n          = 1'b0;
		is_machine     = 1'b0;
		waveform       = wave_res_discharge;
		ton            = 16'(ton_us);
		toff           = 16'(toff_us);
		sample_current = '0;
		sample_voltage = sample_w'(200);
		gap_mode       = mode_noise;
		n_checks       = 0;
		n_errors       = 0;
		n_timeouts     = 0;
		test_reset();
		test_wait_timeout();
		test_res_discharge();
		test_buck();
		test_overcurrent();
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d", n_checks,
			n_errors, n_timeouts, UUT.u_gate_driver.leg_checks.fail_count);
		if (n_errors == 0 && n_timeouts == 0 && UUT.u_gate_driver.leg_checks.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: hdl/breakdown_detect.sv
`timescale 1ns/1ns

module breakdown_detect (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic signed [pulse_timing_pkg::sample_w-1:0] sample_current,
	input  logic signed [pulse_timing_pkg::sample_w-1:0] sample_voltage,
	pulse_if.det                                         bus
);
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	logic [qual_cnt_w-1:0] qual_cnt; // consecutive qualifying samples
	logic                  gap_fired;

	// gap voltage collapses while current starts to flow
	assign gap_fired = (sample_voltage < breakdown_vol_threshold)
		&& (sample_current > breakdown_cur_threshold);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			qual_cnt      <= '0;
			bus.breakdown <= 1'b0;
		end
		else if (bus.state != wait_breakdown)
		begin
			// only valid while the gap is open
			qual_cnt      <= '0;
			bus.breakdown <= 1'b0;
		end
		else if (bus.breakdown)
		begin
			qual_cnt <= qual_cnt; // latched until state leaves wait
		end
		else if (gap_fired)
		begin
			if (qual_cnt == qual_cnt_w'(breakdown_qual_cycles - 1))
				bus.breakdown <= 1'b1;
			else
				qual_cnt <= qual_cnt + 1'b1;
		end
		else
		begin
			qual_cnt <= '0; // noise spike, start over
		end
	end

endmodule

// File: hdl/buck_phase_gen.sv
`timescale 1ns/1ns

module buck_phase_gen (
	input  logic                           clk,
	input  logic                           rst_n,
	pulse_if.leg                           bus,
	output discharge_mode_pkg::leg_drive_t phase0_drive,
	output discharge_mode_pkg::leg_drive_t phase180_drive
);
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	logic [buck_cnt_w-1:0] cnt0;       // phase 0 position, 0..399
	logic [buck_cnt_w-1:0] cnt180;     // phase 180 position, 400 means idle
	logic [rise_cnt_w-1:0] period_cnt; // completed periods, saturates
	logic [buck_cnt_w-1:0] charge0;
	logic [buck_cnt_w-1:0] charge180;  // held for half a period
	logic                  in_buck;
	logic                  restart180;
	logic                  period_end;
	logic                  idle180;

	// off, up for charge, off, then down for the rest of the period
	function automatic leg_drive_t phase_drive(
		input logic [buck_cnt_w-1:0] cnt,
		input logic [buck_cnt_w-1:0] charge,
		input logic                  allow_down
	);
		leg_drive_t drv;
		if (cnt < dead_time_cycles)
			drv = leg_off;                       // lower switch turning off
		else if (cnt < dead_time_cycles + charge)
			drv = leg_up;                        // charge inductor
		else if (cnt < 2 * dead_time_cycles + charge)
			drv = leg_off;                       // upper switch turning off
		else if (allow_down)
			drv = leg_down;                      // freewheel
		else
			drv = leg_off;
		return drv;
	endfunction

	assign in_buck    = (bus.state == buck_interleave);
	assign restart180 = in_buck && (cnt0 == buck_cnt_w'(buck_half_cycles - 1));
	assign period_end = in_buck && (cnt0 == buck_cnt_w'(buck_period_cycles - 1));
	assign idle180    = (cnt180 == buck_cnt_w'(buck_period_cycles));

	// rise value first, then stand value
	assign charge0 = (period_cnt < rise_period_count) ?
		buck_cnt_w'(rise_charge_cycles) : buck_cnt_w'(stand_charge_cycles);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt0       <= '0;
			cnt180     <= buck_cnt_w'(buck_period_cycles);
			period_cnt <= '0;
		end
		else if (!in_buck)
		begin
			cnt0       <= '0;
			cnt180     <= buck_cnt_w'(buck_period_cycles); // idle until first restart
			period_cnt <= '0;
		end
		else
		begin
			cnt0 <= period_end ? '0 : cnt0 + 1'b1;
			if (restart180)
				cnt180 <= '0;
			else if (!idle180)
				cnt180 <= cnt180 + 1'b1;
			if (period_end && period_cnt != rise_cnt_w'(rise_period_count))
				period_cnt <= period_cnt + 1'b1;
		end
	end

	// phase 180 uses the charge time valid at its restart
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			charge180 <= buck_cnt_w'(rise_charge_cycles);
		else if (restart180)
			charge180 <= charge0;
	end

	assign phase0_drive = phase_drive(cnt0, charge0, 1'b1);

	// no freewheel on phase 180 before phase 0 closes its first period
	assign phase180_drive = idle180 ? leg_off :
		phase_drive(cnt180, charge180, period_cnt != '0);

endmodule

// File: hdl/discharge_mode_pkg.sv
package discharge_mode_pkg;

	// waveform codes
	// bit 15 selects res discharge, the low bits pick the buck shape
	localparam logic [15:0] wave_res_discharge = 16'h8000;
	localparam logic [15:0] wave_buck_openloop = 16'h0001; // continuous open loop buck

	// discharge cycle states
	// deion -> wait_breakdown -> (buck_interleave | res_discharge) -> deion
	typedef enum logic [1:0] {
		deion,            // interpulse, legs clamped low
		wait_breakdown,   // gap open, waiting for ionisation
		buck_interleave,  // two phase buck discharge
		res_discharge     // resistive discharge through res leg 1
	} disch_state_t;

	// half bridge leg code
	// upper bit drives the upper switch, lower bit the lower switch
	// 2'b11 would short the supply
	typedef enum logic [1:0] {
		leg_off  = 2'b00, // both switches open
		leg_down = 2'b01, // lower switch on
		leg_up   = 2'b10  // upper switch on
	} leg_drive_t;

endpackage

// File: hdl/gate_driver.sv
`timescale 1ns/1ns

module gate_driver (
	input  logic                           clk,
	input  logic                           rst_n,
	pulse_if.leg                           bus,
	input  discharge_mode_pkg::leg_drive_t phase0_drive,
	input  discharge_mode_pkg::leg_drive_t phase180_drive,
	output logic [1:0]                     mosfet_buck1,
	output logic [1:0]                     mosfet_buck2,
	output logic [1:0]                     mosfet_res1,
	output logic [1:0]                     mosfet_res2,
	output logic                           mosfet_deion
);
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	logic deion_entry; // dead time after entering deion
	logic deion_exit;  // dead time before leaving deion

	assign deion_entry = (bus.state_time < dead_time_cycles);
	// legs open for the last dead time of deion
	assign deion_exit  = (bus.state_time + dead_time_cycles >= bus.toff_cycles);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mosfet_buck1 <= leg_off;
			mosfet_buck2 <= leg_off;
			mosfet_res1  <= leg_off;
			mosfet_res2  <= leg_off;
			mosfet_deion <= 1'b0;
		end
		else
		begin
			case (bus.state)
				deion:
				begin
					if (deion_entry)
					begin
						// buck legs arrive up or down, only up needs the gap
						if (mosfet_buck1 == leg_up)
							mosfet_buck1 <= leg_off;
						if (mosfet_buck2 == leg_up)
							mosfet_buck2 <= leg_off;
						mosfet_res1  <= leg_down;
						mosfet_res2  <= leg_down;
						mosfet_deion <= 1'b0;
					end
					else if (deion_exit)
					begin
						mosfet_buck1 <= leg_off; // all open before res1 goes up
						mosfet_buck2 <= leg_off;
						mosfet_res1  <= leg_off;
						mosfet_res2  <= leg_off;
						mosfet_deion <= 1'b0;
					end
					else
					begin
						mosfet_buck1 <= leg_down; // interpulse clamp
						mosfet_buck2 <= leg_down;
						mosfet_res1  <= leg_down;
						mosfet_res2  <= leg_down;
						mosfet_deion <= 1'b1;     // deion circuit on
					end
				end
				wait_breakdown:
				begin
					mosfet_buck1 <= leg_off;
					mosfet_buck2 <= leg_off;
					mosfet_res1  <= leg_up;       // open circuit voltage on the gap
					mosfet_res2  <= leg_off;
					mosfet_deion <= 1'b0;
				end
				buck_interleave:
				begin
					mosfet_buck1 <= phase0_drive;
					mosfet_buck2 <= phase180_drive;
					mosfet_res1  <= leg_up;       // kept from wait
					mosfet_res2  <= leg_off;
					mosfet_deion <= 1'b0;
				end
				default: // res_discharge
				begin
					mosfet_buck1 <= leg_off;
					mosfet_buck2 <= leg_off;
					mosfet_res1  <= leg_up;
					mosfet_res2  <= leg_off;
					mosfet_deion <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: hdl/mos_control.sv
`timescale 1ns/1ns

module mos_control (
	input  logic                                         clk,        // 100 MHz
	input  logic                                         rst_n,
	input  logic                                         is_machine, // machine start
	input  logic [15:0]                                  waveform,
	input  logic [15:0]                                  ton,        // discharge time, us
	input  logic [15:0]                                  toff,       // interpulse time, us
	input  logic signed [pulse_timing_pkg::sample_w-1:0] sample_current,
	input  logic signed [pulse_timing_pkg::sample_w-1:0] sample_voltage,
	output logic [1:0]                                   mosfet_buck1, // up, down
	output logic [1:0]                                   mosfet_buck2,
	output logic [1:0]                                   mosfet_res1,
	output logic [1:0]                                   mosfet_res2,
	output logic                                         mosfet_deion,
	output logic                                         is_operation,
	output logic                                         is_breakdown
);
	import discharge_mode_pkg::*;

	pulse_if    bus ();      // state and timing shared by all blocks
	leg_drive_t phase0_drive;
	leg_drive_t phase180_drive;

	pulse_sequencer u_sequencer (
		.clk            (clk),
		.rst_n          (rst_n),
		.is_machine     (is_machine),
		.waveform       (waveform),
		.ton            (ton),
		.toff           (toff),
		.sample_current (sample_current),
		.is_operation   (is_operation),
		.bus            (bus)
	);

	breakdown_detect u_breakdown (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_current (sample_current),
		.sample_voltage (sample_voltage),
		.bus            (bus)
	);

	buck_phase_gen u_buck_phase (
		.clk            (clk),
		.rst_n          (rst_n),
		.bus            (bus),
		.phase0_drive   (phase0_drive),
		.phase180_drive (phase180_drive)
	);

	gate_driver u_gate_driver (
		.clk            (clk),
		.rst_n          (rst_n),
		.bus            (bus),
		.phase0_drive   (phase0_drive),
		.phase180_drive (phase180_drive),
		.mosfet_buck1   (mosfet_buck1),
		.mosfet_buck2   (mosfet_buck2),
		.mosfet_res1    (mosfet_res1),
		.mosfet_res2    (mosfet_res2),
		.mosfet_deion   (mosfet_deion)
	);

	assign is_breakdown = bus.breakdown; // indicator for the operator panel

endmodule

// File: hdl/pulse_if.sv
`timescale 1ns/1ns

interface pulse_if;
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	disch_state_t         state;       // sequencer state
	logic [timer_w-1:0]   state_time;  // cycles in current state, 0 on entry
	logic [timer_w-1:0]   ton_cycles;  // ton scaled to clock cycles
	logic [timer_w-1:0]   toff_cycles; // toff scaled to clock cycles
	logic                 breakdown;   // gap has broken down

	// sequencer owns state and timing
	modport seq (
		output state,
		output state_time,
		output ton_cycles,
		output toff_cycles,
		input  breakdown
	);

	// breakdown detector
	modport det (
		input  state,
		output breakdown
	);

	// leg logic only listens
	modport leg (
		input  state,
		input  state_time,
		input  ton_cycles,
		input  toff_cycles,
		input  breakdown
	);

endinterface

// File: hdl/pulse_sequencer.sv
`timescale 1ns/1ns

module pulse_sequencer (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         is_machine,
	input  logic [15:0]                                  waveform,
	input  logic [15:0]                                  ton,  // us
	input  logic [15:0]                                  toff, // us
	input  logic signed [pulse_timing_pkg::sample_w-1:0] sample_current,
	output logic                                         is_operation,
	pulse_if.seq                                         bus
);
	import pulse_timing_pkg::*;
	import discharge_mode_pkg::*;

	logic signed [sample_w:0] total_current; // both buck phases together
	logic                     is_overcurrent;
	disch_state_t             next_state;

	// one phase is sampled, total current is twice that
	assign total_current = $signed({sample_current, 1'b0});

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			is_overcurrent <= 1'b0;
		else
			is_overcurrent <= (total_current > max_current_limit);
	end

	// second register after the sample
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			is_operation <= 1'b0;
		else
			is_operation <= is_machine && !is_overcurrent;
	end

	// us to cycles, registered to keep the multiplier off the fsm path
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bus.ton_cycles  <= '0;
			bus.toff_cycles <= '0;
		end
		else
		begin
			bus.ton_cycles  <= timer_w'(ton) * timer_w'(us_cycles);
			bus.toff_cycles <= timer_w'(toff) * timer_w'(us_cycles);
		end
	end

	always_comb
	begin
		next_state = bus.state; // hold by default
		case (bus.state)
			deion:
			begin
				if (bus.state_time >= bus.toff_cycles && is_operation)
					next_state = wait_breakdown;
			end
			wait_breakdown:
			begin
				if (!is_operation)
					next_state = deion;
				else if (bus.breakdown && waveform == wave_buck_openloop)
					next_state = buck_interleave;
				else if (bus.breakdown && waveform == wave_res_discharge)
					next_state = res_discharge;
				else if (!bus.breakdown && bus.state_time >= wait_breakdown_max_cycles)
					next_state = deion; // gap never fired
			end
			buck_interleave:
			begin
				if (bus.state_time >= bus.ton_cycles)
					next_state = deion; // runs full ton even on overcurrent
			end
			res_discharge:
			begin
				if (bus.state_time >= bus.ton_cycles || !is_operation)
					next_state = deion;
			end
			default: next_state = deion;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bus.state      <= deion;
			bus.state_time <= '0;
		end
		else
		begin
			bus.state <= next_state;
			if (next_state != bus.state)
				bus.state_time <= '0; // restart timer on every transition
			else
				bus.state_time <= bus.state_time + 1'b1;
		end
	end

endmodule

// File: hdl/pulse_timing_pkg.sv
package pulse_timing_pkg;

	// clock is 100 MHz so one cycle is 10 ns
	localparam int us_cycles = 100;          // cycles per microsecond for ton and toff

	// leg switching
	localparam int dead_time_cycles = 10;    // 100 ns between leg transitions

	// buck switching period, 250 kHz
	localparam int buck_period_cycles = 400;
	localparam int buck_half_cycles = 200;   // phase 180 restart point

	// open loop charging time ramp
	localparam int rise_charge_cycles = 120; // charging time while current rises
	localparam int stand_charge_cycles = 80; // charging time once current stands
	localparam int rise_period_count = 3;    // periods spent on the rise value

	// gap supervision
	localparam int wait_breakdown_max_cycles = 10000;
	localparam int max_current_limit = 76;   // compared against the doubled sample
	localparam int breakdown_vol_threshold = 40;
	localparam int breakdown_cur_threshold = 10;
	localparam int breakdown_qual_cycles = 10;

	// word widths
	localparam int sample_w = 16;            // adc word
	localparam int timer_w = 32;             // state timer and scaled ton / toff

	// counter widths derived from the constants above
	localparam int buck_cnt_w = $clog2(buck_period_cycles + 1);
	localparam int rise_cnt_w = $clog2(rise_period_count + 1);
	localparam int qual_cnt_w = $clog2(breakdown_qual_cycles);

endpackage

// File: project.f
hdl/pulse_timing_pkg.sv
hdl/discharge_mode_pkg.sv
hdl/pulse_if.sv
hdl/pulse_sequencer.sv
hdl/breakdown_detect.sv
hdl/buck_phase_gen.sv
hdl/gate_driver.sv
hdl/mos_control.sv
dv/mos_control_properties.sv
dv/mos_control_tb.sv
